// File: source/csr_pkg.sv
package csr_pkg;

  // Data width is fixed, RV32 only
  localparam int xlen = 32;

  typedef logic [11:0] csr_addr_t;

  // Supervisor views
  localparam csr_addr_t addr_sstatus = 12'h100;
  localparam csr_addr_t addr_sie = 12'h104;
  localparam csr_addr_t addr_sepc = 12'h141;
  localparam csr_addr_t addr_scause = 12'h142;
  localparam csr_addr_t addr_sip = 12'h144;

  // Machine registers
  localparam csr_addr_t addr_mstatus = 12'h300;
  localparam csr_addr_t addr_mie = 12'h304;
  localparam csr_addr_t addr_mepc = 12'h341;
  localparam csr_addr_t addr_mcause = 12'h342;
  localparam csr_addr_t addr_mip = 12'h344;

  // mstatus fields, mpp is two bits wide starting here
  localparam int stat_sie = 1;
  localparam int stat_mie = 3;
  localparam int stat_spie = 5;
  localparam int stat_mpie = 7;
  localparam int stat_spp = 8;
  localparam int stat_mpp = 11;
  localparam int stat_mprv = 17;

  // Interrupt bits in mip/mie, also the interrupt cause codes
  localparam int irq_ssi = 1;
  localparam int irq_msi = 3;
  localparam int irq_sti = 5;
  localparam int irq_mti = 7;
  localparam int irq_sei = 9;
  localparam int irq_mei = 11;

  // Synchronous exception codes
  localparam int cause_illegal = 2;
  localparam int cause_ecall_u = 8;
  localparam int cause_ecall_s = 9;
  localparam int cause_ecall_m = 11;

  // Encoding 2 is reserved
  typedef enum logic [1:0] {
    priv_user       = 2'b00,
    priv_supervisor = 2'b01,
    priv_machine    = 2'b11
  } priv_t;

  typedef struct packed {
    logic            strobe;
    logic            write;
    csr_addr_t       addr;
    logic [xlen-1:0] wdata;
  } csr_req_t;

  // Per-cycle events from the hart pipeline
  typedef struct packed {
    logic            illegal_instruction;
    logic            ecall;
    logic            mret;
    logic            sret;
    logic [xlen-1:0] pc;
  } trap_event_t;

  typedef struct packed {
    logic msip;
    logic ssip;
    logic mtip;
    logic meip;
  } irq_lines_t;

  typedef struct packed {
    logic            take;
    logic            interrupt;
    logic [xlen-2:0] cause;
  } trap_decision_t;

endpackage

// File: source/csr_arbiter.sv
`timescale 1ns/100ps

module csr_arbiter import csr_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  csr_req_t        hart_req,
  input  csr_req_t        debug_req,
  output csr_req_t        bus_req,
  output logic            debug_wait,
  input  logic [xlen-1:0] bus_rdata,
  output logic [xlen-1:0] hart_rdata,
  output logic [xlen-1:0] debug_rdata
);

  logic hart_grant;
  logic debug_grant;
  // Debug request was held off last cycle
  logic debug_held;

  // Hart always wins, debug only gets an idle bus
  assign hart_grant = hart_req.strobe;
  assign debug_grant = debug_req.strobe && !hart_req.strobe;

  // Collision, debug keeps its request up and retries
  assign debug_wait = debug_req.strobe && hart_req.strobe;

  always_comb begin
    if (hart_grant) begin
      bus_req = hart_req;
    end else begin
      // Strobe is low here unless debug asks
      bus_req = debug_req;
    end
  end

  // Read data only reaches the master that owns the bus
  assign hart_rdata = hart_grant ? bus_rdata : '0;
  assign debug_rdata = debug_grant ? bus_rdata : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      debug_held <= 1'b0;
    end else begin
      debug_held <= debug_wait;
    end
  end

endmodule

// File: source/trap_control.sv
`timescale 1ns/100ps

module trap_control import csr_pkg::*; (
  input  trap_event_t     events,
  input  logic [xlen-1:0] pending,
  input  logic [xlen-1:0] enabled,
  input  logic            status_mie,
  input  logic            status_sie,
  input  priv_t           priv,
  output trap_decision_t  decision
);

  logic [xlen-1:0] active;
  logic [xlen-1:0] taken;
  logic            m_allowed;
  logic            s_allowed;
  logic            irq_any;
  logic [xlen-2:0] irq_cause;

  assign active = pending & enabled;

  // Machine interrupts: any lower mode, or M with global enable
  assign m_allowed = (priv != priv_machine) || status_mie;
  // Supervisor interrupts never preempt M
  assign s_allowed = (priv == priv_user) || ((priv == priv_supervisor) && status_sie);

  always_comb begin
    taken = '0;
    taken[irq_mei] = active[irq_mei] && m_allowed;
    taken[irq_mti] = active[irq_mti] && m_allowed;
    taken[irq_msi] = active[irq_msi] && m_allowed;
    taken[irq_sei] = active[irq_sei] && s_allowed;
    taken[irq_sti] = active[irq_sti] && s_allowed;
    taken[irq_ssi] = active[irq_ssi] && s_allowed;
  end

  assign irq_any = |taken;

  // Fixed order MEI, MTI, MSI, SEI, STI, SSI
  always_comb begin
    irq_cause = '0;
    if (taken[irq_mei]) begin
      irq_cause = (xlen-1)'(irq_mei);
    end else if (taken[irq_mti]) begin
      irq_cause = (xlen-1)'(irq_mti);
    end else if (taken[irq_msi]) begin
      irq_cause = (xlen-1)'(irq_msi);
    end else if (taken[irq_sei]) begin
      irq_cause = (xlen-1)'(irq_sei);
    end else if (taken[irq_sti]) begin
      irq_cause = (xlen-1)'(irq_sti);
    end else if (taken[irq_ssi]) begin
      irq_cause = (xlen-1)'(irq_ssi);
    end
  end

  always_comb begin
    decision = '0;
    if (irq_any) begin
      decision.take = 1'b1;
      decision.interrupt = 1'b1;
      decision.cause = irq_cause;
    end else if (events.illegal_instruction) begin
      decision.take = 1'b1;
      decision.cause = (xlen-1)'(cause_illegal);
    end else if (events.ecall) begin
      // 8, 9 or 11 depending on the calling mode
      decision.take = 1'b1;
      decision.cause = (xlen-1)'(cause_ecall_u) + (xlen-1)'(priv);
    end
  end

endmodule

// File: source/csr_file.sv
`timescale 1ns/100ps

module csr_file import csr_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  csr_req_t        bus_req,
  output logic [xlen-1:0] rdata,
  input  trap_event_t     events,
  input  trap_decision_t  decision,
  input  irq_lines_t      irq,
  input  logic            external_interrupt,
  output logic [xlen-1:0] pending,
  output logic [xlen-1:0] enabled,
  output logic            status_mie,
  output logic            status_sie,
  output priv_t           priv,
  output logic [xlen-1:0] mepc,
  output logic [xlen-1:0] sepc
);

  // Interrupt bits visible from S-mode, and all implemented ones
  localparam logic [xlen-1:0] s_irq_mask =
      (xlen'(1) << irq_ssi) | (xlen'(1) << irq_sti) | (xlen'(1) << irq_sei);
  localparam logic [xlen-1:0] m_irq_mask =
      s_irq_mask | (xlen'(1) << irq_msi) | (xlen'(1) << irq_mti) | (xlen'(1) << irq_mei);

  logic            write_en;
  logic [xlen-1:0] wdata;
  logic            mstatus_mie;
  logic            mstatus_sie;
  logic            mstatus_mpie;
  logic            mstatus_spie;
  logic            mstatus_spp;
  logic            mstatus_mprv;
  logic [1:0]      mstatus_mpp;
  priv_t           priv_q;
  logic [xlen-1:0] mie_q;
  logic            stip_q;
  logic            seip_q;
  logic [xlen-1:0] mepc_q;
  logic [xlen-1:0] sepc_q;
  logic [xlen-1:0] mcause_q;
  logic [xlen-1:0] scause_q;
  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] sstatus;
  logic [xlen-1:0] mip;
  logic [xlen-1:0] sip;
  logic [xlen-1:0] sie_view;

  // WLRL check on the incoming write value
  function automatic logic legal_cause(input logic [xlen-1:0] value);
    logic [xlen-2:0] code;
    code = value[xlen-2:0];
    if (value[xlen-1]) begin
      return code inside {irq_ssi, irq_msi, irq_sti, irq_mti, irq_sei, irq_mei};
    end
    return code inside {cause_illegal, cause_ecall_u, cause_ecall_s, cause_ecall_m};
  endfunction

  // A trap in the same cycle drops the CSR write
  assign write_en = bus_req.strobe && bus_req.write && !decision.take;
  assign wdata = bus_req.wdata;

  // Status bits, priority trap > mret > sret > CSR write
  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus_mie <= 1'b0;
      mstatus_sie <= 1'b0;
      mstatus_mpie <= 1'b0;
      mstatus_spie <= 1'b0;
      mstatus_spp <= 1'b0;
      mstatus_mprv <= 1'b0;
      mstatus_mpp <= 2'b00;
    end else if (decision.take) begin
      // Every trap lands in M
      mstatus_mie <= 1'b0;
      mstatus_mpie <= mstatus_mie;
      mstatus_mpp <= priv_q;
    end else if (events.mret) begin
      mstatus_mie <= mstatus_mpie;
      mstatus_mpie <= 1'b1;
      mstatus_mpp <= priv_machine;
      if (mstatus_mpp != priv_machine) begin
        mstatus_mprv <= 1'b0;
      end
    end else if (events.sret) begin
      mstatus_sie <= mstatus_spie;
      mstatus_spie <= 1'b1;
      mstatus_spp <= 1'b1;
      mstatus_mprv <= 1'b0;
    end else if (write_en && bus_req.addr == addr_mstatus) begin
      mstatus_mie <= wdata[stat_mie];
      mstatus_sie <= wdata[stat_sie];
      mstatus_mpie <= wdata[stat_mpie];
      mstatus_spie <= wdata[stat_spie];
      mstatus_spp <= wdata[stat_spp];
      mstatus_mprv <= wdata[stat_mprv];
      // Reserved mode 2 is not stored
      if (wdata[stat_mpp +: 2] != 2'b10) begin
        mstatus_mpp <= wdata[stat_mpp +: 2];
      end
    end else if (write_en && bus_req.addr == addr_sstatus) begin
      mstatus_sie <= wdata[stat_sie];
      mstatus_spie <= wdata[stat_spie];
      mstatus_spp <= wdata[stat_spp];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      priv_q <= priv_machine;
    end else if (decision.take) begin
      priv_q <= priv_machine;
    end else if (events.mret) begin
      priv_q <= priv_t'(mstatus_mpp);
    end else if (events.sret) begin
      priv_q <= priv_t'({1'b0, mstatus_spp});
    end
  end

  // Interrupt enables, sie only reaches the supervisor bits
  always_ff @(posedge clock) begin
    if (reset) begin
      mie_q <= '0;
    end else if (write_en && bus_req.addr == addr_mie) begin
      mie_q <= wdata & m_irq_mask;
    end else if (write_en && bus_req.addr == addr_sie) begin
      mie_q <= (mie_q & ~s_irq_mask) | (wdata & s_irq_mask);
    end
  end

  // Software-set supervisor pending bits, M-mode only
  always_ff @(posedge clock) begin
    if (reset) begin
      stip_q <= 1'b0;
      seip_q <= 1'b0;
    end else if (write_en && priv_q == priv_machine &&
                 (bus_req.addr == addr_mip || bus_req.addr == addr_sip)) begin
      stip_q <= wdata[irq_sti];
      seip_q <= wdata[irq_sei];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mepc_q <= '0;
      mcause_q <= '0;
    end else if (decision.take) begin
      mepc_q <= events.pc;
      mcause_q <= {decision.interrupt, decision.cause};
    end else begin
      if (write_en && bus_req.addr == addr_mepc) begin
        mepc_q <= {wdata[xlen-1:2], 2'b00};
      end
      if (write_en && bus_req.addr == addr_mcause && legal_cause(wdata)) begin
        mcause_q <= wdata;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sepc_q <= '0;
      scause_q <= '0;
    end else begin
      if (write_en && bus_req.addr == addr_sepc) begin
        sepc_q <= {wdata[xlen-1:2], 2'b00};
      end
      if (write_en && bus_req.addr == addr_scause && legal_cause(wdata)) begin
        scause_q <= wdata;
      end
    end
  end

  always_comb begin
    mstatus = '0;
    mstatus[stat_sie] = mstatus_sie;
    mstatus[stat_mie] = mstatus_mie;
    mstatus[stat_spie] = mstatus_spie;
    mstatus[stat_mpie] = mstatus_mpie;
    mstatus[stat_spp] = mstatus_spp;
    mstatus[stat_mpp +: 2] = mstatus_mpp;
    mstatus[stat_mprv] = mstatus_mprv;
  end

  // sstatus drops mie, mpie, mpp and mprv
  always_comb begin
    sstatus = '0;
    sstatus[stat_sie] = mstatus_sie;
    sstatus[stat_spie] = mstatus_spie;
    sstatus[stat_spp] = mstatus_spp;
  end

  always_comb begin
    mip = '0;
    mip[irq_ssi] = irq.ssip;
    mip[irq_msi] = irq.msip;
    mip[irq_sti] = stip_q;
    mip[irq_mti] = irq.mtip;
    mip[irq_sei] = seip_q;
    mip[irq_mei] = external_interrupt || irq.meip;
  end

  assign sip = mip & s_irq_mask;
  assign sie_view = mie_q & s_irq_mask;

  always_comb begin
    case (bus_req.addr)
      addr_sstatus: rdata = sstatus;
      addr_sie:     rdata = sie_view;
      addr_sepc:    rdata = sepc_q;
      addr_scause:  rdata = scause_q;
      addr_sip:     rdata = sip;
      addr_mstatus: rdata = mstatus;
      addr_mie:     rdata = mie_q;
      addr_mepc:    rdata = mepc_q;
      addr_mcause:  rdata = mcause_q;
      addr_mip:     rdata = mip;
      default:      rdata = '0;
    endcase
  end

  assign pending = mip;
  assign enabled = mie_q;
  assign status_mie = mstatus_mie;
  assign status_sie = mstatus_sie;
  assign priv = priv_q;
  assign mepc = mepc_q;
  assign sepc = sepc_q;

endmodule

// File: source/clint_timer.sv
`timescale 1ns/100ps

module clint_timer import csr_pkg::*; #(
  parameter int tick_divide = 1
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            mem_write,
  input  logic [2:0]      mem_select,
  input  logic [xlen-1:0] mem_wdata,
  output irq_lines_t      irq
);

  // At least one bit, also for a divider of 1
  localparam int count_width = (tick_divide > 1) ? $clog2(tick_divide) : 1;

  logic [count_width-1:0] prescale;
  logic                   tick;
  logic [63:0]            mtime;
  logic [63:0]            mtimecmp;
  logic                   msip_q;
  logic                   ssip_q;
  logic                   mtip_q;

  assign tick = (prescale == count_width'(tick_divide - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      prescale <= '0;
    end else if (tick) begin
      prescale <= '0;
    end else begin
      prescale <= prescale + 1'b1;
    end
  end

  // A bus write takes precedence over the tick
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else if (mem_write && mem_select == 3'd0) begin
      mtime[31:0] <= mem_wdata;
    end else if (mem_write && mem_select == 3'd1) begin
      mtime[63:32] <= mem_wdata;
    end else if (tick) begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // All ones keeps mtip quiet out of reset
      mtimecmp <= '1;
      msip_q <= 1'b0;
      ssip_q <= 1'b0;
    end else if (mem_write) begin
      case (mem_select)
        3'd2: mtimecmp[31:0] <= mem_wdata;
        3'd3: mtimecmp[63:32] <= mem_wdata;
        3'd4: msip_q <= mem_wdata[0];
        3'd5: ssip_q <= mem_wdata[0];
        default: ;
      endcase
    end
  end

  // Registered compare, one cycle behind mtime
  always_ff @(posedge clock) begin
    if (reset) begin
      mtip_q <= 1'b0;
    end else begin
      mtip_q <= (mtime >= mtimecmp);
    end
  end

  assign irq.msip = msip_q;
  assign irq.ssip = ssip_q;
  assign irq.mtip = mtip_q;
  // External interrupt enters at the CSR file
  assign irq.meip = 1'b0;

endmodule

// File: source/csr_subsystem.sv
`timescale 1ns/100ps

module csr_subsystem import csr_pkg::*; #(
  parameter int tick_divide = 1
) (
  input  logic            clock,
  input  logic            reset,
  input  csr_req_t        hart_req,
  input  csr_req_t        debug_req,
  output logic [xlen-1:0] hart_rdata,
  output logic [xlen-1:0] debug_rdata,
  output logic            debug_wait,
  input  trap_event_t     events,
  input  logic            external_interrupt,
  input  logic            mem_write,
  input  logic [2:0]      mem_select,
  input  logic [xlen-1:0] mem_wdata,
  output logic            trap,
  output logic [xlen-1:0] trap_cause,
  output priv_t           priv,
  output logic [xlen-1:0] mepc,
  output logic [xlen-1:0] sepc
);

  csr_req_t        bus_req;
  logic [xlen-1:0] bus_rdata;
  logic [xlen-1:0] pending;
  logic [xlen-1:0] enabled;
  logic            status_mie;
  logic            status_sie;
  trap_decision_t  decision;
  irq_lines_t      irq;

  csr_arbiter csr_arbiter_inst (
    .clock       (clock),
    .reset       (reset),
    .hart_req    (hart_req),
    .debug_req   (debug_req),
    .bus_req     (bus_req),
    .debug_wait  (debug_wait),
    .bus_rdata   (bus_rdata),
    .hart_rdata  (hart_rdata),
    .debug_rdata (debug_rdata)
  );

  trap_control trap_control_inst (
    .events     (events),
    .pending    (pending),
    .enabled    (enabled),
    .status_mie (status_mie),
    .status_sie (status_sie),
    .priv       (priv),
    .decision   (decision)
  );

  csr_file csr_file_inst (
    .clock              (clock),
    .reset              (reset),
    .bus_req            (bus_req),
    .rdata              (bus_rdata),
    .events             (events),
    .decision           (decision),
    .irq                (irq),
    .external_interrupt (external_interrupt),
    .pending            (pending),
    .enabled            (enabled),
    .status_mie         (status_mie),
    .status_sie         (status_sie),
    .priv               (priv),
    .mepc               (mepc),
    .sepc               (sepc)
  );

  clint_timer #(
    .tick_divide (tick_divide)
  ) clint_timer_inst (
    .clock      (clock),
    .reset      (reset),
    .mem_write  (mem_write),
    .mem_select (mem_select),
    .mem_wdata  (mem_wdata),
    .irq        (irq)
  );

  assign trap = decision.take;
  assign trap_cause = {decision.interrupt, decision.cause};

endmodule

// File: testbench/csr_subsystem_props.sv
`timescale 1ns/100ps

module csr_subsystem_props import csr_pkg::*; (
  input logic     clock,
  input logic     reset,
  input csr_req_t debug_req,
  input logic     debug_held,
  input logic     trap,
  input priv_t    priv
);

  // A held-off debug request comes back unchanged for its retry
  held_debug_request_stable: assert property (
    @(posedge clock) disable iff (reset) debug_held |-> debug_req.strobe && $stable(debug_req)
  ) else $error("debug request changed while held off");

  trap_quiet_after_reset: assert property (
    @(posedge clock) $fell(reset) |-> !trap
  ) else $error("trap high in first cycle after reset");

  // Encoding 2 is reserved
  no_reserved_priv: assert property (
    @(posedge clock) disable iff (reset) priv != 2'b10
  ) else $error("privilege holds reserved value");

  trap_enters_machine: assert property (
    @(posedge clock) disable iff (reset) trap |=> priv == priv_machine
  ) else $error("privilege not machine after trap");

endmodule

// File: testbench/csr_subsystem_tb.sv
`timescale 1ns/100ps

module csr_subsystem_tb import csr_pkg::*; ();

  localparam logic [31:0] s_mask = 32'h0000_0222;
  localparam logic [31:0] m_mask = 32'h0000_0aaa;
  localparam int timeout_cycles = 2000;

  logic            clock;
  logic            reset;
  csr_req_t        hart_req;
  csr_req_t        debug_req;
  trap_event_t     events;
  logic            external_interrupt;
  logic            mem_write;
  logic [2:0]      mem_select;
  logic [31:0]     mem_wdata;
  logic [31:0]     hart_rdata;
  logic [31:0]     debug_rdata;
  logic            debug_wait;
  logic            trap;
  logic [31:0]     trap_cause;
  priv_t           priv_out;
  logic [31:0]     mepc_out;
  logic [31:0]     sepc_out;

  // Reference model state
  logic        m_mie, m_sie, m_mpie, m_spie, m_spp, m_mprv;
  logic [1:0]  m_mpp;
  logic [1:0]  m_priv;
  logic [31:0] m_ie;
  logic        m_stip, m_seip, m_msip, m_ssip, m_mtip;
  logic [31:0] m_mepc, m_sepc, m_mcause, m_scause;
  logic [63:0] m_mtime, m_mtimecmp;
  int          m_prescale;
  logic        ext_level;

  csr_addr_t addr_list [10] = '{addr_sstatus, addr_sie, addr_sepc, addr_scause, addr_sip,
                                addr_mstatus, addr_mie, addr_mepc, addr_mcause, addr_mip};

  csr_subsystem #(.tick_divide(4)) csr_subsystem_inst (
    .clock(clock), .reset(reset), .hart_req(hart_req), .debug_req(debug_req),
    .hart_rdata(hart_rdata), .debug_rdata(debug_rdata), .debug_wait(debug_wait),
    .events(events), .external_interrupt(external_interrupt), .mem_write(mem_write),
    .mem_select(mem_select), .mem_wdata(mem_wdata), .trap(trap), .trap_cause(trap_cause),
    .priv(priv_out), .mepc(mepc_out), .sepc(sepc_out)
  );

  bind csr_arbiter csr_subsystem_props arbiter_props (
    .clock(clock), .reset(reset), .debug_req(debug_req),
    .debug_held(debug_held), .trap(1'b0), .priv(priv_machine)
  );

  bind csr_file csr_subsystem_props file_props (
    .clock(clock), .reset(reset), .debug_req('0),
    .debug_held(1'b0), .trap(decision.take), .priv(priv_q)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic timed_out(input string what);
    $display("Timeout while waiting for %s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic csr_req_t make_req(input logic s, input logic w, input csr_addr_t a,
                                        input logic [31:0] d);
    csr_req_t r;
    r.strobe = s;
    r.write = w;
    r.addr = a;
    r.wdata = d;
    return r;
  endfunction

  function automatic logic [31:0] model_mip();
    logic [31:0] v;
    v = '0;
    v[1] = m_ssip;
    v[3] = m_msip;
    v[5] = m_stip;
    v[7] = m_mtip;
    v[9] = m_seip;
    v[11] = ext_level;
    return v;
  endfunction

  function automatic logic [31:0] model_read(input csr_addr_t a);
    logic [31:0] st;
    st = '0;
    st[1] = m_sie;
    st[3] = m_mie;
    st[5] = m_spie;
    st[7] = m_mpie;
    st[8] = m_spp;
    st[12:11] = m_mpp;
    st[17] = m_mprv;
    case (a)
      addr_sstatus: return st & 32'h0000_0122;
      addr_sie:     return m_ie & s_mask;
      addr_sepc:    return m_sepc;
      addr_scause:  return m_scause;
      addr_sip:     return model_mip() & s_mask;
      addr_mstatus: return st;
      addr_mie:     return m_ie;
      addr_mepc:    return m_mepc;
      addr_mcause:  return m_mcause;
      addr_mip:     return model_mip();
      default:      return '0;
    endcase
  endfunction

  function automatic logic cause_ok(input logic [31:0] v);
    if (v[31]) begin
      return v[30:0] inside {1, 3, 5, 7, 9, 11};
    end
    return v[30:0] inside {2, 8, 9, 11};
  endfunction

  // Bit 32 is take, low word is the cause word
  function automatic logic [32:0] model_decision(input trap_event_t ev);
    int order [6] = '{11, 7, 3, 9, 5, 1};
    logic [31:0] act;
    logic m_ok;
    logic s_ok;
    act = model_mip() & m_ie;
    m_ok = (m_priv != 2'b11) || m_mie;
    s_ok = (m_priv == 2'b00) || ((m_priv == 2'b01) && m_sie);
    foreach (order[i]) begin
      if (act[order[i]] && ((order[i] % 4 == 3) ? m_ok : s_ok)) begin
        return {1'b1, 1'b1, 31'(order[i])};
      end
    end
    if (ev.illegal_instruction) begin
      return {1'b1, 32'd2};
    end
    if (ev.ecall) begin
      return {1'b1, 32'd8 + 32'(m_priv)};
    end
    return '0;
  endfunction

  task automatic model_edge(input csr_req_t g, input trap_event_t ev, input logic [32:0] dec,
                            input logic mw, input logic [2:0] ms, input logic [31:0] md);
    logic wr;
    logic [31:0] v;
    logic [1:0] old_priv;
    logic mtip_next;
    logic tick;
    wr = g.strobe && g.write && !dec[32];
    v = g.wdata;
    old_priv = m_priv;
    if (dec[32]) begin
      m_mpie = m_mie;
      m_mie = 1'b0;
      m_mpp = m_priv;
      m_priv = 2'b11;
      m_mepc = ev.pc;
      m_mcause = dec[31:0];
    end else if (ev.mret) begin
      m_mie = m_mpie;
      m_mpie = 1'b1;
      if (m_mpp != 2'b11) m_mprv = 1'b0;
      m_priv = m_mpp;
      m_mpp = 2'b11;
    end else if (ev.sret) begin
      m_sie = m_spie;
      m_spie = 1'b1;
      m_priv = {1'b0, m_spp};
      m_spp = 1'b1;
      m_mprv = 1'b0;
    end else if (wr && g.addr == addr_mstatus) begin
      {m_sie, m_mie, m_spie, m_mpie, m_spp, m_mprv} = {v[1], v[3], v[5], v[7], v[8], v[17]};
      if (v[12:11] != 2'b10) m_mpp = v[12:11];
    end else if (wr && g.addr == addr_sstatus) begin
      {m_sie, m_spie, m_spp} = {v[1], v[5], v[8]};
    end
    if (wr) begin
      case (g.addr)
        addr_mie: m_ie = v & m_mask;
        addr_sie: m_ie = (m_ie & ~s_mask) | (v & s_mask);
        addr_mip, addr_sip: begin
          if (old_priv == 2'b11) begin
            m_stip = v[5];
            m_seip = v[9];
          end
        end
        addr_mepc: m_mepc = v & ~32'h3;
        addr_sepc: m_sepc = v & ~32'h3;
        addr_mcause: if (cause_ok(v)) m_mcause = v;
        addr_scause: if (cause_ok(v)) m_scause = v;
        default: ;
      endcase
    end
    // Timer, compare uses values from before the edge
    mtip_next = m_mtime >= m_mtimecmp;
    tick = m_prescale == 3;
    m_prescale = tick ? 0 : m_prescale + 1;
    if (mw && ms == 3'd0) m_mtime[31:0] = md;
    else if (mw && ms == 3'd1) m_mtime[63:32] = md;
    else if (tick) m_mtime = m_mtime + 64'd1;
    if (mw) begin
      case (ms)
        3'd2: m_mtimecmp[31:0] = md;
        3'd3: m_mtimecmp[63:32] = md;
        3'd4: m_msip = md[0];
        3'd5: m_ssip = md[0];
        default: ;
      endcase
    end
    m_mtip = mtip_next;
  endtask

  // Starts and ends on a falling edge
  task automatic cycle(input string name, input csr_req_t h, input csr_req_t d,
                       input trap_event_t ev, input logic mw, input logic [2:0] ms,
                       input logic [31:0] md, output logic took);
    logic [32:0] dec;
    hart_req = h;
    debug_req = d;
    events = ev;
    external_interrupt = ext_level;
    mem_write = mw;
    mem_select = ms;
    mem_wdata = md;
    #20;
    dec = model_decision(ev);
    check_value({name, " hart_rdata"}, h.strobe ? model_read(h.addr) : '0, hart_rdata);
    check_value({name, " debug_rdata"},
                (d.strobe && !h.strobe) ? model_read(d.addr) : '0, debug_rdata);
    check_value({name, " debug_wait"}, 32'(h.strobe && d.strobe), 32'(debug_wait));
    check_value({name, " trap"}, 32'(dec[32]), 32'(trap));
    check_value({name, " trap_cause"}, dec[31:0], trap_cause);
    check_value({name, " priv"}, 32'(m_priv), 32'(priv_out));
    check_value({name, " mepc"}, m_mepc, mepc_out);
    check_value({name, " sepc"}, m_sepc, sepc_out);
    took = trap;
    @(posedge clock);
    model_edge(h.strobe ? h : d, ev, dec, mw, ms, md);
    @(negedge clock);
  endtask

  task automatic hart_op(input string name, input logic w, input csr_addr_t a,
                         input logic [31:0] d);
    logic took;
    cycle(name, make_req(1'b1, w, a, d), '0, '0, 1'b0, 3'd0, '0, took);
  endtask

  task automatic mem_op(input logic [2:0] sel, input logic [31:0] d);
    logic took;
    cycle("timer write", '0, '0, '0, 1'b1, sel, d, took);
  endtask

  task automatic event_op(input string name, input trap_event_t ev, output logic took);
    cycle(name, '0, '0, ev, 1'b0, 3'd0, '0, took);
  endtask

  task automatic back_to_machine();
    trap_event_t ev;
    logic took;
    int n;
    ev = '0;
    ev.ecall = 1'b1;
    n = 0;
    while (m_priv != 2'b11) begin
      if (n > 8) timed_out("return to machine mode");
      event_op("ecall to machine", ev, took);
      n++;
    end
  endtask

  function automatic logic [1:0] random_mode();
    case ($urandom % 3)
      0: return 2'b00;
      1: return 2'b01;
      default: return 2'b11;
    endcase
  endfunction

  initial begin
    trap_event_t ev;
    csr_req_t h;
    csr_req_t d;
    logic [31:0] st;
    logic [31:0] base;
    logic took;
    logic hold;
    int n;
    int pred;
    void'($urandom(32'h6db7a9ba));
    hart_req = '0;
    debug_req = '0;
    events = '0;
    external_interrupt = 1'b0;
    mem_write = 1'b0;
    mem_select = '0;
    mem_wdata = '0;
    ext_level = 1'b0;
    reset = 1'b1;
    {m_mie, m_sie, m_mpie, m_spie, m_spp, m_mprv, m_mpp} = '0;
    {m_stip, m_seip, m_msip, m_ssip, m_mtip} = '0;
    {m_ie, m_mepc, m_sepc, m_mcause, m_scause, m_mtime} = '0;
    m_priv = 2'b11;
    m_mtimecmp = '1;
    m_prescale = 0;
    repeat (10) @(negedge clock);
    reset = 1'b0;

    // Reset state
    foreach (addr_list[i]) hart_op("reset read", 1'b0, addr_list[i], '0);
    hart_op("unlisted read", 1'b0, 12'h7c0, '0);

    // Random write then read back
    repeat (200) begin
      h = make_req(1'b1, 1'b1, addr_list[$urandom % 10], $urandom);
      hart_op("random write", 1'b1, h.addr, h.wdata);
      hart_op("random readback", 1'b0, h.addr, '0);
    end
    hart_op("clear mie", 1'b1, addr_mie, '0);
    hart_op("clear mip", 1'b1, addr_mip, '0);

    // Trap entry and return
    repeat (20) begin
      st = $urandom & 32'h0002_01a2;
      st[12:11] = ($urandom % 2) ? 2'b01 : 2'b00;
      hart_op("trap setup", 1'b1, addr_mstatus, st);
      ev = '0;
      ev.mret = 1'b1;
      event_op("mret to lower mode", ev, took);
      ev = '0;
      ev.pc = $urandom;
      if ($urandom % 2) ev.illegal_instruction = 1'b1;
      else ev.ecall = 1'b1;
      event_op("trap entry", ev, took);
      check_value("trap entry taken", 1, 32'(took));
      hart_op("mcause after trap", 1'b0, addr_mcause, '0);
      st = $urandom & 32'h0002_01a2;
      st[12:11] = random_mode();
      hart_op("return setup", 1'b1, addr_mstatus, st);
      ev = '0;
      ev.mret = 1'b1;
      event_op("mret", ev, took);
      hart_op("mstatus after mret", 1'b0, addr_mstatus, '0);
      if (m_priv == 2'b01) begin
        ev = '0;
        ev.sret = 1'b1;
        event_op("sret", ev, took);
        hart_op("sstatus after sret", 1'b0, addr_sstatus, '0);
      end
      back_to_machine();
    end

    // Interrupt priority and mode masking
    repeat (40) begin
      hart_op("irq quiet", 1'b1, addr_mstatus, '0);
      hart_op("irq stip seip", 1'b1, addr_mip, $urandom);
      hart_op("irq enables", 1'b1, addr_mie, $urandom);
      mem_op(3'd4, $urandom);
      mem_op(3'd5, $urandom);
      if ($urandom % 2) begin
        mem_op(3'd2, '0);
        mem_op(3'd3, '0);
      end else begin
        mem_op(3'd3, 32'hffff_ffff);
      end
      ext_level = $urandom % 2;
      hart_op("irq settle", 1'b0, addr_mip, '0);
      hart_op("irq settle", 1'b0, addr_mip, '0);
      st = $urandom & 32'h0000_01a2;
      st[12:11] = random_mode();
      hart_op("irq mode setup", 1'b1, addr_mstatus, st);
      ev = '0;
      ev.mret = 1'b1;
      event_op("irq mret", ev, took);
      event_op("irq decision", '0, took);
      back_to_machine();
    end
    ext_level = 1'b0;
    hart_op("irq cleanup", 1'b1, addr_mie, '0);
    hart_op("irq cleanup", 1'b1, addr_mip, '0);
    mem_op(3'd4, '0);
    mem_op(3'd5, '0);
    mem_op(3'd3, 32'hffff_ffff);

    // Timer crossing
    repeat (3) begin
      mem_op(3'd1, '0);
      base = $urandom & 32'h0000_0fff;
      mem_op(3'd0, base);
      mem_op(3'd2, base + 12 + ($urandom % 16));
      mem_op(3'd3, '0);
      hart_op("timer enable", 1'b1, addr_mie, 32'h80);
      hart_op("timer global", 1'b1, addr_mstatus, 32'h8);
      pred = (3 - m_prescale) + 4 * (int'(m_mtimecmp - m_mtime) - 1) + 2;
      n = 0;
      took = 1'b0;
      while (!took) begin
        if (n > timeout_cycles) timed_out("timer interrupt");
        event_op("timer wait", '0, took);
        n++;
      end
      check_value("timer crossing window", 1, 32'((n - 1 >= pred - 4) && (n - 1 <= pred + 4)));
      mem_op(3'd3, 32'hffff_ffff);
      hart_op("timer cleanup", 1'b1, addr_mie, '0);
    end

    // Arbitration between hart and debug
    repeat (200) begin
      h = make_req($urandom % 2, $urandom % 2, addr_list[$urandom % 10], $urandom);
      d = make_req($urandom % 2, $urandom % 2, addr_list[$urandom % 10], $urandom);
      cycle("arbitration", h, d, '0, 1'b0, 3'd0, '0, took);
      hold = debug_wait;
      n = 0;
      while (hold) begin
        if (n > 8) timed_out("held debug request");
        cycle("debug retry", '0, d, '0, 1'b0, 3'd0, '0, took);
        hold = debug_wait;
        n++;
      end
      if (d.strobe && d.write) begin
        cycle("debug readback", '0, make_req(1'b1, 1'b0, d.addr, '0), '0, 1'b0, 3'd0, '0,
              took);
      end
    end

    $display("all tests passed");
    $finish;
  end

endmodule

// File: src.f
source/csr_pkg.sv
source/csr_arbiter.sv
source/trap_control.sv
source/csr_file.sv
source/clint_timer.sv
source/csr_subsystem.sv
testbench/csr_subsystem_props.sv
testbench/csr_subsystem_tb.sv

// File: Bender.yml
package:
  name: csr_subsystem

sources:
  - source/csr_pkg.sv
  - source/csr_arbiter.sv
  - source/trap_control.sv
  - source/csr_file.sv
  - source/clint_timer.sv
  - source/csr_subsystem.sv
  - target: test
    files:
      - testbench/csr_subsystem_props.sv
      - testbench/csr_subsystem_tb.sv
